//--- rtl/icache_pkg.sv
`default_nettype none

package icache_pkg;

   //////////////////////////////
   // Fixed widths
   //////////////////////////////

   // Byte address on fetch and refill side
   localparam int FETCH_ADDR_WIDTH = 32;
   // One instruction word, also one cache line
   localparam int FETCH_DATA_WIDTH = 32;
   // Byte offset inside a line
   localparam int LINE_OFFSET_BITS = 2;

   //////////////////////////////
   // Vector types
   //////////////////////////////

   typedef logic [FETCH_ADDR_WIDTH-1:0] addr_t;
   typedef logic [FETCH_DATA_WIDTH-1:0] data_t;

   // Address without offset, stored whole as the tag
   typedef logic [FETCH_ADDR_WIDTH-LINE_OFFSET_BITS-1:0] line_addr_t;

   // Tag entry of one row
   typedef struct packed {
      logic       valid;
      line_addr_t line;
   } tag_entry_t;

   // Fetch request payload
   typedef struct packed {
      addr_t addr;
   } fetch_req_t;

   // Refill request payload, word aligned
   typedef struct packed {
      addr_t addr;
   } refill_req_t;

   // Controller FSM
   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      REFILL_REQ,
      REFILL_WAIT,
      RESPOND,
      FLUSH
   } ctrl_state_t;

endpackage

`default_nettype wire

//--- rtl/icache_tag_bank.sv
`default_nettype none

module icache_tag_bank
   import icache_pkg::*;
#(
   parameter int NB_SETS = 16,
   localparam int IDX_W = $clog2(NB_SETS)
)
(
   input  logic             clk,
   input  logic             rst_n_i,
   input  logic             rd_en_i,
   input  logic             wr_en_i,
   input  logic [IDX_W-1:0] index_i,
   input  tag_entry_t       wdata_i,
   input  logic             flush_i,
   output tag_entry_t       rdata_o
);

   // Valid bits, one per row
   logic [NB_SETS-1:0] valid_q;
   // Stored line addresses
   line_addr_t         line_q [NB_SETS];

   // Reset and flush both wipe every valid bit
   always_ff @(posedge clk)
   begin
      if (!rst_n_i || flush_i)
         valid_q <= '0;
      else if (wr_en_i)
         valid_q[index_i] <= wdata_i.valid;
   end

   // Line storage and registered read port
   always_ff @(posedge clk)
   begin
      if (wr_en_i)
         line_q[index_i] <= wdata_i.line;
      if (rd_en_i)
      begin
         rdata_o.valid <= valid_q[index_i];
         rdata_o.line  <= line_q[index_i];
      end
   end

endmodule

`default_nettype wire

//--- rtl/icache_data_bank.sv
`default_nettype none

module icache_data_bank
   import icache_pkg::*;
#(
   parameter int NB_SETS = 16,
   localparam int IDX_W = $clog2(NB_SETS)
)
(
   input  logic             clk,
   input  logic             rd_en_i,
   input  logic             wr_en_i,
   input  logic [IDX_W-1:0] index_i,
   input  data_t            wdata_i,
   output data_t            rdata_o
);

   // One instruction word per row
   data_t mem_q [NB_SETS];

   // Write port on the shared index
   always_ff @(posedge clk)
   begin
      if (wr_en_i)
         mem_q[index_i] <= wdata_i;
   end

   // Read data one cycle after the enable
   always_ff @(posedge clk)
   begin
      if (rd_en_i)
         rdata_o <= mem_q[index_i];
   end

endmodule

`default_nettype wire

//--- rtl/icache_refill_buffer.sv
`default_nettype none

module icache_refill_buffer
   import icache_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n_i,
   input  logic  valid_i,
   input  data_t data_i,
   output logic  valid_o,
   output data_t data_o
);

   // Two entries, so single bit pointers
   data_t       mem_q [2];
   logic        wr_ptr_q;
   logic        rd_ptr_q;
   logic [1:0]  count_q;
   logic        push;
   logic        pop;

   // Input has no ready, every beat is taken
   assign push = valid_i;
   // Consumer always accepts
   assign pop  = (count_q != 2'd0);

   assign valid_o = pop;
   assign data_o  = mem_q[rd_ptr_q];

   //////////////////////////////
   // Pointers and fill level
   //////////////////////////////
   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_q <= 1'b0;
         rd_ptr_q <= 1'b0;
         count_q  <= 2'd0;
      end
      else
      begin
         if (push)
            wr_ptr_q <= ~wr_ptr_q;
         if (pop)
            rd_ptr_q <= ~rd_ptr_q;
         // Net change of one entry at most
         if (push && !pop)
            count_q <= count_q + 2'd1;
         else if (pop && !push)
            count_q <= count_q - 2'd1;
      end
   end

   // Entry storage
   always_ff @(posedge clk)
   begin
      if (push)
         mem_q[wr_ptr_q] <= data_i;
   end

endmodule

`default_nettype wire

//--- rtl/icache_controller.sv
`default_nettype none

module icache_controller
   import icache_pkg::*;
#(
   parameter int NB_WAYS = 2,
   parameter int NB_SETS = 16,
   localparam int IDX_W = $clog2(NB_SETS)
)
(
   input  logic                      clk,
   input  logic                      rst_n_i,

   // Fetch side
   input  logic                      fetch_req_valid_i,
   input  fetch_req_t                fetch_req_i,
   output logic                      fetch_req_ready_o,
   output logic                      fetch_rsp_valid_o,
   output data_t                     fetch_rsp_data_o,
   input  logic                      fetch_rsp_ready_i,

   // Refill side
   output logic                      refill_req_valid_o,
   output refill_req_t               refill_req_o,
   input  logic                      refill_req_ready_i,
   input  logic                      refill_rsp_valid_i,
   input  data_t                     refill_rsp_data_i,

   // Mode control
   input  logic                      bypass_i,
   output logic                      cache_is_bypassed_o,
   input  logic                      flush_i,
   output logic                      cache_is_flushed_o,

   // Bank control
   output logic [NB_WAYS-1:0]        tag_rd_en_o,
   output logic [NB_WAYS-1:0]        tag_wr_en_o,
   output logic [NB_WAYS-1:0]        data_rd_en_o,
   output logic [NB_WAYS-1:0]        data_wr_en_o,
   output logic [IDX_W-1:0]          index_o,
   output tag_entry_t                tag_wdata_o,
   output data_t                     data_wdata_o,
   output logic                      tag_flush_o,
   input  tag_entry_t [NB_WAYS-1:0]  tag_rdata_i,
   input  data_t [NB_WAYS-1:0]       data_rdata_i
);

   localparam int WAY_W = (NB_WAYS > 1) ? $clog2(NB_WAYS) : 1;

   ctrl_state_t        state_q, state_d;
   addr_t              addr_q;
   logic               bypass_q;
   logic               flushed_q, flushed_d;
   data_t              rsp_data_q, rsp_data_d;
   logic [WAY_W-1:0]   victim_q;
   logic [NB_WAYS-1:0] victim_onehot;
   line_addr_t         req_line;
   logic               accept;
   logic               alloc;
   logic               hit_any;
   data_t              hit_data;

   assign accept   = fetch_req_valid_i && fetch_req_ready_o;
   assign req_line = addr_q[FETCH_ADDR_WIDTH-1:LINE_OFFSET_BITS];

   // Index comes from the live request while idle
   assign index_o = (state_q == IDLE) ? fetch_req_i.addr[LINE_OFFSET_BITS +: IDX_W]
                                      : addr_q[LINE_OFFSET_BITS +: IDX_W];

   //////////////////////////////
   // Hit detection
   //////////////////////////////
   always_comb
   begin
      hit_any  = 1'b0;
      hit_data = '0;
      // Full line address compare on every way
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (tag_rdata_i[w].valid && (tag_rdata_i[w].line == req_line))
         begin
            hit_any  = 1'b1;
            hit_data = data_rdata_i[w];
         end
      end
   end

   //////////////////////////////
   // Next state and outputs
   //////////////////////////////
   always_comb
   begin
      state_d            = state_q;
      flushed_d          = flushed_q;
      rsp_data_d         = rsp_data_q;
      alloc              = 1'b0;
      fetch_req_ready_o  = 1'b0;
      fetch_rsp_valid_o  = 1'b0;
      refill_req_valid_o = 1'b0;
      tag_rd_en_o        = '0;
      data_rd_en_o       = '0;
      tag_flush_o        = 1'b0;
      unique case (state_q)
         IDLE:
         begin
            // Pending flush blocks new fetches
            fetch_req_ready_o = !flush_i;
            if (flush_i)
            begin
               state_d   = FLUSH;
               flushed_d = 1'b1;
            end
            else if (fetch_req_valid_i)
            begin
               if (bypass_i)
                  state_d = REFILL_REQ;
               else
               begin
                  // Read all ways in parallel
                  tag_rd_en_o  = '1;
                  data_rd_en_o = '1;
                  state_d      = LOOKUP;
               end
            end
         end
         LOOKUP:
         begin
            if (hit_any)
            begin
               rsp_data_d = hit_data;
               state_d    = RESPOND;
            end
            else
               state_d = REFILL_REQ;
         end
         REFILL_REQ:
         begin
            refill_req_valid_o = 1'b1;
            if (refill_req_ready_i)
               state_d = REFILL_WAIT;
         end
         REFILL_WAIT:
         begin
            if (refill_rsp_valid_i)
            begin
               rsp_data_d = refill_rsp_data_i;
               // No allocation for bypassed fetches
               alloc      = !bypass_q;
               if (!bypass_q)
                  flushed_d = 1'b0;
               state_d = RESPOND;
            end
         end
         RESPOND:
         begin
            fetch_rsp_valid_o = 1'b1;
            if (fetch_rsp_ready_i)
               state_d = IDLE;
         end
         FLUSH:
         begin
            // One cycle strobe to every tag bank
            tag_flush_o = 1'b1;
            state_d     = IDLE;
         end
         default:
            state_d = IDLE;
      endcase
   end

   // Refill request and fetch response
   assign refill_req_o     = '{addr: {req_line, {LINE_OFFSET_BITS{1'b0}}}};
   assign fetch_rsp_data_o = rsp_data_q;

   // Victim write ports
   assign victim_onehot = NB_WAYS'(1) << victim_q;
   assign tag_wr_en_o   = alloc ? victim_onehot : '0;
   assign data_wr_en_o  = alloc ? victim_onehot : '0;
   assign tag_wdata_o   = '{valid: 1'b1, line: req_line};
   assign data_wdata_o  = refill_rsp_data_i;

   assign cache_is_bypassed_o = (state_q == IDLE) && bypass_i;
   assign cache_is_flushed_o  = flushed_q;

   //////////////////////////////
   // Registers
   //////////////////////////////
   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         state_q   <= IDLE;
         // All valid bits are cleared by reset
         flushed_q <= 1'b1;
         bypass_q  <= 1'b0;
         victim_q  <= '0;
      end
      else
      begin
         state_q   <= state_d;
         flushed_q <= flushed_d;
         if (accept)
            bypass_q <= bypass_i;
         // Round robin over the ways
         if (alloc)
            victim_q <= (victim_q == WAY_W'(NB_WAYS - 1)) ? '0 : victim_q + 1'b1;
      end
   end

   // Request address and response payload
   always_ff @(posedge clk)
   begin
      if (accept)
         addr_q <= fetch_req_i.addr;
      rsp_data_q <= rsp_data_d;
   end

endmodule

`default_nettype wire

//--- rtl/icache_top.sv
`default_nettype none

module icache_top
   import icache_pkg::*;
#(
   parameter int NB_WAYS = 2,
   parameter int NB_SETS = 16
)
(
   input  logic        clk,
   input  logic        rst_n_i,

   // Fetch port
   input  logic        fetch_req_valid_i,
   input  fetch_req_t  fetch_req_i,
   output logic        fetch_req_ready_o,
   output logic        fetch_rsp_valid_o,
   output data_t       fetch_rsp_data_o,
   input  logic        fetch_rsp_ready_i,

   // Refill port
   output logic        refill_req_valid_o,
   output refill_req_t refill_req_o,
   input  logic        refill_req_ready_i,
   input  logic        refill_rsp_valid_i,
   input  data_t       refill_rsp_data_i,

   // Bypass and flush
   input  logic        bypass_i,
   output logic        cache_is_bypassed_o,
   input  logic        flush_i,
   output logic        cache_is_flushed_o
);

   localparam int IDX_W = $clog2(NB_SETS);

   // Bank side
   logic [NB_WAYS-1:0]       tag_rd_en;
   logic [NB_WAYS-1:0]       tag_wr_en;
   logic [NB_WAYS-1:0]       data_rd_en;
   logic [NB_WAYS-1:0]       data_wr_en;
   logic [IDX_W-1:0]         index;
   tag_entry_t               tag_wdata;
   data_t                    data_wdata;
   logic                     tag_flush;
   tag_entry_t [NB_WAYS-1:0] tag_rdata;
   data_t [NB_WAYS-1:0]      data_rdata;

   // Buffered refill response
   logic  rsp_valid;
   data_t rsp_data;

   //////////////////////////////
   // Controller
   //////////////////////////////
   icache_controller #(
      .NB_WAYS ( NB_WAYS ),
      .NB_SETS ( NB_SETS )
   ) icache_controller_i (
      .clk                 ( clk                 ),
      .rst_n_i             ( rst_n_i             ),
      .fetch_req_valid_i   ( fetch_req_valid_i   ),
      .fetch_req_i         ( fetch_req_i         ),
      .fetch_req_ready_o   ( fetch_req_ready_o   ),
      .fetch_rsp_valid_o   ( fetch_rsp_valid_o   ),
      .fetch_rsp_data_o    ( fetch_rsp_data_o    ),
      .fetch_rsp_ready_i   ( fetch_rsp_ready_i   ),
      .refill_req_valid_o  ( refill_req_valid_o  ),
      .refill_req_o        ( refill_req_o        ),
      .refill_req_ready_i  ( refill_req_ready_i  ),
      .refill_rsp_valid_i  ( rsp_valid           ),
      .refill_rsp_data_i   ( rsp_data            ),
      .bypass_i            ( bypass_i            ),
      .cache_is_bypassed_o ( cache_is_bypassed_o ),
      .flush_i             ( flush_i             ),
      .cache_is_flushed_o  ( cache_is_flushed_o  ),
      .tag_rd_en_o         ( tag_rd_en           ),
      .tag_wr_en_o         ( tag_wr_en           ),
      .data_rd_en_o        ( data_rd_en          ),
      .data_wr_en_o        ( data_wr_en          ),
      .index_o             ( index               ),
      .tag_wdata_o         ( tag_wdata           ),
      .data_wdata_o        ( data_wdata          ),
      .tag_flush_o         ( tag_flush           ),
      .tag_rdata_i         ( tag_rdata           ),
      .data_rdata_i        ( data_rdata          )
   );

   // Refill responses land here first
   icache_refill_buffer icache_refill_buffer_i (
      .clk     ( clk                ),
      .rst_n_i ( rst_n_i            ),
      .valid_i ( refill_rsp_valid_i ),
      .data_i  ( refill_rsp_data_i  ),
      .valid_o ( rsp_valid          ),
      .data_o  ( rsp_data           )
   );

   //////////////////////////////
   // One tag and one data bank per way
   //////////////////////////////
   for (genvar w = 0; w < NB_WAYS; w++)
   begin : gen_way
      icache_tag_bank #(
         .NB_SETS ( NB_SETS )
      ) tag_bank_i (
         .clk     ( clk          ),
         .rst_n_i ( rst_n_i      ),
         .rd_en_i ( tag_rd_en[w] ),
         .wr_en_i ( tag_wr_en[w] ),
         .index_i ( index        ),
         .wdata_i ( tag_wdata    ),
         .flush_i ( tag_flush    ),
         .rdata_o ( tag_rdata[w] )
      );

      icache_data_bank #(
         .NB_SETS ( NB_SETS )
      ) data_bank_i (
         .clk     ( clk           ),
         .rd_en_i ( data_rd_en[w] ),
         .wr_en_i ( data_wr_en[w] ),
         .index_i ( index         ),
         .wdata_i ( data_wdata    ),
         .rdata_o ( data_rdata[w] )
      );
   end

endmodule

`default_nettype wire

//--- verif/tb_l2_model.sv
`default_nettype none

module tb_l2_model
   import icache_pkg::*;
#(
   parameter int SEED = 32'h1288
)
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        req_valid_i,
   input  refill_req_t req_i,
   output logic        req_ready_o,
   output logic        rsp_valid_o,
   output data_t       rsp_data_o
);

   timeunit 1ns;
   timeprecision 1ps;

   integer seed;
   // Address of the one refill in flight
   addr_t  pend_addr;
   // Cycles left until the answer or zero when idle
   int     delay;
   // Reset level as of the last rising edge
   logic   rst_seen;
   // Random ready choice of this cycle
   logic   ready_draw;

   initial
   begin
      seed        = SEED;
      delay       = 0;
      pend_addr   = '0;
      rst_seen    = 1'b0;
      ready_draw  = 1'b0;
      req_ready_o = 1'b0;
      rsp_valid_o = 1'b0;
      rsp_data_o  = '0;
      forever
      begin
         // Handshake sampled as the DUT sees it
         @(posedge clk_i);
         rst_seen = rst_n_i;
         if (rst_n_i && req_valid_i && req_ready_o)
         begin
            pend_addr = req_i.addr;
            delay     = 1 + ($unsigned($random(seed)) % 4);
         end
         // Outputs change on the falling edge only
         @(negedge clk_i);
         rsp_valid_o = 1'b0;
         if (delay > 0)
         begin
            delay = delay - 1;
            if (delay == 0)
            begin
               // Single beat of the word address XOR a fixed pattern
               rsp_valid_o = 1'b1;
               rsp_data_o  = pend_addr ^ 32'hA5A5_0000;
            end
         end
         // One draw per cycle, also while in reset
         ready_draw  = ($random(seed) & 1) != 0;
         req_ready_o = rst_seen && ready_draw;
      end
   end

endmodule

`default_nettype wire

//--- verif/tb_icache.sv
`default_nettype none

module tb_icache
   import icache_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int    NB_WAYS    = 2;
   localparam int    NB_SETS    = 16;
   localparam int    CLK_PERIOD = 40;
   localparam int    LINE_POOL  = 40;
   localparam int    N_WARM     = 120;
   localparam int    N_MIXED    = 40;
   localparam int    N_BYP      = 40;
   localparam int    N_FINAL    = 40;
   // Two single fetches around the first flush
   localparam int    N_FETCH    = N_WARM + N_MIXED + N_BYP + N_FINAL + 2;
   localparam addr_t POOL_BASE  = 32'h0002_3000;
   localparam data_t PATTERN    = 32'hA5A5_0000;

   logic        clk;
   logic        rst_n;
   logic        fetch_req_valid;
   fetch_req_t  fetch_req;
   logic        fetch_req_ready;
   logic        fetch_rsp_valid;
   data_t       fetch_rsp_data;
   logic        fetch_rsp_ready;
   logic        refill_req_valid;
   refill_req_t refill_req;
   logic        refill_req_ready;
   logic        refill_rsp_valid;
   data_t       refill_rsp_data;
   logic        bypass;
   logic        bypassed;
   logic        flush;
   logic        flushed;

   // Stimulus bookkeeping
   integer      seed = 32'h1288;
   int          mismatches;
   int          other_errors;
   int          fetches_done;
   logic        exp_hit;
   logic        exp_refill;
   logic        last_valid;
   logic        after_flush;
   line_addr_t  last_line;
   addr_t       prev_addr;

   // Monitor state
   int          cycle;
   int          acc_cycle;
   int          refills;
   logic        in_flight;
   logic        rsp_seen;
   logic        cur_hit;
   logic        cur_refill;
   logic        cur_byp;
   addr_t       cur_addr;
   logic        prev_rsp_valid;
   logic        prev_rsp_ready;
   data_t       prev_rsp_data;
   logic        prev_ref_valid;
   logic        prev_ref_ready;
   refill_req_t prev_ref_req;

   always #(CLK_PERIOD / 2) clk = ~clk;

   icache_top #(
      .NB_WAYS ( NB_WAYS ),
      .NB_SETS ( NB_SETS )
   ) icache_top_i (
      .clk                 ( clk              ),
      .rst_n_i             ( rst_n            ),
      .fetch_req_valid_i   ( fetch_req_valid  ),
      .fetch_req_i         ( fetch_req        ),
      .fetch_req_ready_o   ( fetch_req_ready  ),
      .fetch_rsp_valid_o   ( fetch_rsp_valid  ),
      .fetch_rsp_data_o    ( fetch_rsp_data   ),
      .fetch_rsp_ready_i   ( fetch_rsp_ready  ),
      .refill_req_valid_o  ( refill_req_valid ),
      .refill_req_o        ( refill_req       ),
      .refill_req_ready_i  ( refill_req_ready ),
      .refill_rsp_valid_i  ( refill_rsp_valid ),
      .refill_rsp_data_i   ( refill_rsp_data  ),
      .bypass_i            ( bypass           ),
      .cache_is_bypassed_o ( bypassed         ),
      .flush_i             ( flush            ),
      .cache_is_flushed_o  ( flushed          )
   );

   tb_l2_model #(
      .SEED ( 32'h1288 )
   ) l2_model_i (
      .clk_i       ( clk              ),
      .rst_n_i     ( rst_n            ),
      .req_valid_i ( refill_req_valid ),
      .req_i       ( refill_req       ),
      .req_ready_o ( refill_req_ready ),
      .rsp_valid_o ( refill_rsp_valid ),
      .rsp_data_o  ( refill_rsp_data  )
   );

   ////////////////////////////////
   // Error reporting
   ////////////////////////////////
   task automatic flag_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      mismatches++;
      $display("MISMATCH %s: got 0x%08h, expected 0x%08h at %0t ns", name, got, exp, $time);
   endtask

   task automatic note_error(input string what);
      other_errors++;
      $display("ERROR at %0t ns: %s", $time, what);
   endtask

   // Word aligned line from the pool, 40 lines over 16 sets
   function automatic addr_t pool_addr(input int idx);
      return POOL_BASE + addr_t'(idx) * 4;
   endfunction

   ////////////////////////////////
   // Stimulus tasks
   ////////////////////////////////
   task automatic run_fetch(input addr_t a, input logic byp);
      logic done;
      @(negedge clk);
      // Same line as the last cached fetch means a hit
      exp_hit    = !byp && last_valid && (a[FETCH_ADDR_WIDTH-1:LINE_OFFSET_BITS] == last_line);
      exp_refill = byp || after_flush;
      fetch_req_valid = 1'b1;
      fetch_req.addr  = a;
      fetch_rsp_ready = ($random(seed) & 3) != 0;
      // Request holds until taken
      @(posedge clk);
      while (!fetch_req_ready)
         @(posedge clk);
      @(negedge clk);
      fetch_req_valid = 1'b0;
      done = 1'b0;
      while (!done)
      begin
         @(posedge clk);
         done = fetch_rsp_valid && fetch_rsp_ready;
         if (!done)
         begin
            // Random back-pressure on the response
            @(negedge clk);
            fetch_rsp_ready = ($random(seed) & 3) != 0;
         end
      end
      last_line   = a[FETCH_ADDR_WIDTH-1:LINE_OFFSET_BITS];
      last_valid  = !byp;
      after_flush = after_flush && byp;
      prev_addr   = a;
      fetches_done++;
   endtask

   task automatic run_phase(input int n, input logic byp);
      addr_t a;
      @(negedge clk);
      bypass = byp;
      for (int i = 0; i < n; i++)
      begin
         // About one fetch in three repeats the last line
         if (i > 0 && ($unsigned($random(seed)) % 3) == 0)
            a = prev_addr;
         else
            a = pool_addr($unsigned($random(seed)) % LINE_POOL);
         run_fetch(a, byp);
      end
   endtask

   task automatic flush_cache();
      @(negedge clk);
      flush = 1'b1;
      // Cache is idle here, so the flush is taken at once
      @(posedge clk);
      @(negedge clk);
      flush       = 1'b0;
      after_flush = 1'b1;
      last_valid  = 1'b0;
      @(posedge clk);
      assert (flushed)
      else note_error("cache_is_flushed_o not high one cycle after the flush");
   endtask

   task automatic check_reset();
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(posedge clk);
      assert (!fetch_rsp_valid) else note_error("fetch_rsp_valid_o high after reset");
      assert (!refill_req_valid) else note_error("refill_req_valid_o high after reset");
      assert (flushed) else note_error("cache_is_flushed_o low after reset");
      assert (fetch_req_ready) else note_error("fetch_req_ready_o low after reset");
   endtask

   ////////////////////////////////
   // Monitor
   ////////////////////////////////
   always @(posedge clk)
   begin
      cycle++;
      if (rst_n)
      begin
         // Stalled response holds
         if (prev_rsp_valid && !prev_rsp_ready)
         begin
            assert (fetch_rsp_valid)
            else note_error("fetch_rsp_valid_o dropped while fetch_rsp_ready_i was low");
            assert (fetch_rsp_data == prev_rsp_data)
            else flag_mismatch("fetch_rsp_data_o", fetch_rsp_data, prev_rsp_data);
         end
         // Stalled refill request holds
         if (prev_ref_valid && !prev_ref_ready)
         begin
            assert (refill_req_valid)
            else note_error("refill_req_valid_o dropped while refill_req_ready_i was low");
            assert (refill_req.addr == prev_ref_req.addr)
            else flag_mismatch("refill_req_o", refill_req.addr, prev_ref_req.addr);
         end
         if (fetch_req_ready && bypass)
         begin
            assert (bypassed)
            else note_error("cache_is_bypassed_o low while ready in bypass mode");
         end
         // New fetch taken
         if (fetch_req_valid && fetch_req_ready)
         begin
            in_flight  = 1'b1;
            rsp_seen   = 1'b0;
            refills    = 0;
            acc_cycle  = cycle;
            cur_addr   = fetch_req.addr;
            cur_hit    = exp_hit;
            cur_refill = exp_refill;
            cur_byp    = bypass;
         end
         if (refill_req_valid)
         begin
            assert (in_flight) else note_error("refill request with no fetch in flight");
            assert (refill_req.addr == {cur_addr[FETCH_ADDR_WIDTH-1:LINE_OFFSET_BITS], 2'b00})
            else flag_mismatch("refill_req_o", refill_req.addr, {cur_addr[31:2], 2'b00});
            if (refill_req_ready)
               refills++;
         end
         if (fetch_rsp_valid)
         begin
            assert (in_flight) else note_error("fetch response with no fetch in flight");
            assert (fetch_rsp_data == (cur_addr ^ PATTERN))
            else flag_mismatch("fetch_rsp_data_o", fetch_rsp_data, cur_addr ^ PATTERN);
            // Timing and refill count on the first response cycle
            if (!rsp_seen)
            begin
               rsp_seen = 1'b1;
               if (cur_hit)
               begin
                  assert (cycle - acc_cycle == 2)
                  else flag_mismatch("hit latency", cycle - acc_cycle, 2);
                  assert (refills == 0) else note_error("refill request seen on a hit");
               end
               if (cur_refill)
               begin
                  assert (refills == 1) else flag_mismatch("refill count", refills, 1);
               end
               if (!cur_byp)
               begin
                  assert (!flushed)
                  else note_error("cache_is_flushed_o still high after a cached fetch");
               end
            end
            if (fetch_rsp_ready)
               in_flight = 1'b0;
         end
      end
      prev_rsp_valid = fetch_rsp_valid;
      prev_rsp_ready = fetch_rsp_ready;
      prev_rsp_data  = fetch_rsp_data;
      prev_ref_valid = refill_req_valid;
      prev_ref_ready = refill_req_ready;
      prev_ref_req   = refill_req;
   end

   // Watchdog sized from the fetch count
   initial
   begin
      #(N_FETCH * 40 * CLK_PERIOD);
      note_error("watchdog expired before all fetches completed");
      $display("SIMULATION FAILED");
      $finish;
   end

   ////////////////////////////////
   // Main sequence
   ////////////////////////////////
   initial
   begin
      clk             = 1'b0;
      rst_n           = 1'b0;
      fetch_req_valid = 1'b0;
      fetch_req       = '0;
      fetch_rsp_ready = 1'b0;
      bypass          = 1'b0;
      flush           = 1'b0;
      mismatches      = 0;
      other_errors    = 0;
      fetches_done    = 0;
      exp_hit         = 1'b0;
      exp_refill      = 1'b0;
      last_valid      = 1'b0;
      // Reset leaves every valid bit cleared
      after_flush     = 1'b1;
      last_line       = '0;
      prev_addr       = POOL_BASE;
      cycle           = 0;
      in_flight       = 1'b0;
      rsp_seen        = 1'b0;
      prev_rsp_valid  = 1'b0;
      prev_ref_valid  = 1'b0;

      check_reset();
      run_phase(N_WARM, 1'b0);
      // Make the last line a hit, then flush it away
      run_fetch(prev_addr, 1'b0);
      flush_cache();
      run_fetch(prev_addr, 1'b0);
      run_phase(N_MIXED, 1'b0);
      run_phase(N_BYP, 1'b1);
      flush_cache();
      run_phase(N_FINAL, 1'b0);

      repeat (4) @(posedge clk);
      $display("fetches: %0d, mismatches: %0d, other errors: %0d",
               fetches_done, mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
rtl/icache_pkg.sv
rtl/icache_tag_bank.sv
rtl/icache_data_bank.sv
rtl/icache_refill_buffer.sv
rtl/icache_controller.sv
rtl/icache_top.sv
verif/tb_l2_model.sv
verif/tb_icache.sv
